// ==== mix_mod10.sv ====
// combinational reduction of the shift count to its even remainder modulo 10, feeds mix_shift
module mix_mod10 (
	input mix_pkg::count_t m,
	output mix_pkg::rem10_t rem10
);
	import mix_pkg::*;

	// partial sums per bit group, counted in units of two bytes
	logic [3:0] sum_g0;
	logic [3:0] sum_g1;
	logic [3:0] sum_g2;
	logic [3:0] sum_g3;

	// one-hot partial remainders
	rem10_t part0;
	rem10_t part1;
	rem10_t part2;
	rem10_t part3;

	// first adder level
	rem10_t lvl1_lo;
	rem10_t lvl1_hi;

	// small sum to one-hot slot, reduced modulo 5
	function automatic rem10_t onehot5(input logic [3:0] v);
		rem10_t r;
		r = '0;
		for (int i = 0; i < REM10_BITS; i++) begin
			r[i] = ((v % REM10_BITS) == i);
		end
		return r;
	endfunction

	// modulo-5 adder on one-hot operands
	function automatic rem10_t add5(input rem10_t a, input rem10_t b);
		rem10_t s;
		s = '0;
		for (int i = 0; i < REM10_BITS; i++) begin
			for (int j = 0; j < REM10_BITS; j++) begin
				s[(i + j) % REM10_BITS] |= a[i] & b[j];
			end
		end
		return s;
	endfunction

	// 2^k mod 10 cycles through 2, 4, 8, 6 from bit 1 upward
	// halved this gives the slot weights 1, 2, 4, 3
	always_comb begin
		sum_g0 = (m[1] ? 4'd1 : 4'd0) + (m[2] ? 4'd2 : 4'd0) + (m[3] ? 4'd4 : 4'd0);
		sum_g1 = (m[4] ? 4'd3 : 4'd0) + (m[5] ? 4'd1 : 4'd0) + (m[6] ? 4'd2 : 4'd0);
		sum_g2 = (m[7] ? 4'd4 : 4'd0) + (m[8] ? 4'd3 : 4'd0) + (m[9] ? 4'd1 : 4'd0);
		sum_g3 = (m[10] ? 4'd2 : 4'd0) + (m[11] ? 4'd4 : 4'd0);
	end

	assign part0 = onehot5(sum_g0);
	assign part1 = onehot5(sum_g1);
	assign part2 = onehot5(sum_g2);
	assign part3 = onehot5(sum_g3);

	// two levels, so the tree stays shallow ahead of the engine register
	assign lvl1_lo = add5(part0, part1);
	assign lvl1_hi = add5(part2, part3);
	assign rem10 = add5(lvl1_lo, lvl1_hi);

endmodule

// ==== mix_pkg.sv ====
// shared sizes, shift field codes and word types for the MIX shift unit, imported by every block
package mix_pkg;

	// a MIX byte holds 64 values
	localparam int BYTE_BITS = 6;

	// five bytes per magnitude, sign kept apart
	localparam int WORD_BYTES = 5;
	localparam int WORD_BITS = BYTE_BITS * WORD_BYTES;

	// field part of the instruction selects the shift
	localparam int FIELD_BITS = 6;

	// shift count m, already resolved from address and index
	localparam int COUNT_BITS = 12;

	// one-hot slots of the even remainder modulo 10
	localparam int REM10_BITS = 5;

	// magnitude of A or X
	typedef logic [WORD_BITS-1:0] mag_t;

	// instruction field
	typedef logic [FIELD_BITS-1:0] field_t;

	// byte count of a shift
	typedef logic [COUNT_BITS-1:0] count_t;

	// one-hot even part of m modulo 10
	// bit i set means a remainder of 2*i, so 0, 2, 4, 6 or 8
	// the odd part is carried by m[0] on its own
	typedef logic [REM10_BITS-1:0] rem10_t;

	// field codes of operation code 6
	// shift left A, signs untouched
	localparam field_t FIELD_SLA = 6'd0;

	// shift right A
	localparam field_t FIELD_SRA = 6'd1;

	// shift left A:X as one ten-byte value
	localparam field_t FIELD_SLAX = 6'd2;

	// shift right A:X
	localparam field_t FIELD_SRAX = 6'd3;

	// rotate A:X left, count taken modulo 10
	localparam field_t FIELD_SLC = 6'd4;

	// rotate A:X right
	localparam field_t FIELD_SRC = 6'd5;

	// codes 6 to 63 are no shift at all
	// the unit still answers with a stop pulse

endpackage

// ==== mix_regs.sv ====
// registers A and X with their signs, preset by the load port and updated on shift stop
module mix_regs (
	input logic clk,
	input logic rst,
	input logic load,
	input mix_pkg::mag_t load_a,
	input mix_pkg::mag_t load_x,
	input logic load_sign_a,
	input logic load_sign_x,
	input mix_pkg::mag_t outa,
	input mix_pkg::mag_t outx,
	input logic stop,
	output mix_pkg::mag_t ra,
	output mix_pkg::mag_t rx,
	output logic sign_a,
	output logic sign_x
);

	// magnitudes, written by load or by a finished shift
	always_ff @(posedge clk) begin
		if (rst) begin
			ra <= '0;
			rx <= '0;
		end else if (load) begin
			ra <= load_a;
			rx <= load_x;
		end else if (stop) begin
			// result is valid in the stop cycle only
			ra <= outa;
			rx <= outx;
		end
	end

	// signs change only through the load port
	always_ff @(posedge clk) begin
		if (rst) begin
			sign_a <= 1'b0;
			sign_x <= 1'b0;
		end else if (load) begin
			sign_a <= load_sign_a;
			sign_x <= load_sign_x;
		end
	end

endmodule

// ==== mix_shift.sv ====
// two-cycle shift engine for A and X, started by a start pulse and finished with a one-cycle stop
module mix_shift (
	input logic clk,
	input logic rst,
	input logic start,
	input mix_pkg::field_t field,
	input mix_pkg::count_t m,
	input mix_pkg::rem10_t rem10,
	input mix_pkg::mag_t ina,
	input mix_pkg::mag_t inx,
	output mix_pkg::mag_t outa,
	output mix_pkg::mag_t outx,
	output logic stop
);
	import mix_pkg::*;

	// field decode, only live during start
	logic sla;
	logic sra;
	logic slax;
	logic srax;
	logic slc;
	logic src;

	// selected shift for the second cycle
	logic sla_q;
	logic sra_q;
	logic slax_q;
	logic srax_q;
	logic slc_q;
	logic src_q;

	// one-hot m/2 for 0 to 4, all zero when the count is larger
	logic [4:0] half_q;
	rem10_t rem_q;

	// result of the one-byte step
	mag_t a_step;
	mag_t x_step;
	mag_t a1;
	mag_t x1;

	logic [2*WORD_BITS-1:0] pair_in;
	logic [2*WORD_BITS-1:0] pair1;
	logic [4*WORD_BITS-1:0] ring;
	logic [4*WORD_BITS-1:0] ring_l;
	logic [4*WORD_BITS-1:0] ring_r;

	// bit distances of the second step
	int unsigned half_amt;
	int unsigned rot_amt;

	// position of the set bit in a five-bit one-hot
	function automatic int unsigned onehot_index(input logic [4:0] oh);
		int unsigned idx;
		idx = 0;
		for (int i = 0; i < 5; i++) begin
			if (oh[i]) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	assign sla = start && (field == FIELD_SLA);
	assign sra = start && (field == FIELD_SRA);
	assign slax = start && (field == FIELD_SLAX);
	assign srax = start && (field == FIELD_SRAX);
	assign slc = start && (field == FIELD_SLC);
	assign src = start && (field == FIELD_SRC);

	always_ff @(posedge clk) begin
		if (rst) begin
			stop <= 1'b0;
			sla_q <= 1'b0;
			sra_q <= 1'b0;
			slax_q <= 1'b0;
			srax_q <= 1'b0;
			slc_q <= 1'b0;
			src_q <= 1'b0;
		end else begin
			stop <= start;
			sla_q <= sla;
			sra_q <= sra;
			slax_q <= slax;
			srax_q <= srax;
			slc_q <= slc;
			src_q <= src;
		end
	end

	// first cycle, the odd byte of the count
	assign pair_in = {ina, inx};

	always_comb begin
		a_step = ina;
		x_step = inx;
		if (m[0]) begin
			if (sla) begin
				a_step = ina << BYTE_BITS;
			end else if (sra) begin
				a_step = ina >> BYTE_BITS;
			end else if (slax) begin
				{a_step, x_step} = pair_in << BYTE_BITS;
			end else if (srax) begin
				{a_step, x_step} = pair_in >> BYTE_BITS;
			end else if (slc) begin
				{a_step, x_step} = {pair_in[2*WORD_BITS-BYTE_BITS-1:0],
					pair_in[2*WORD_BITS-1:2*WORD_BITS-BYTE_BITS]};
			end else if (src) begin
				{a_step, x_step} = {pair_in[BYTE_BITS-1:0],
					pair_in[2*WORD_BITS-1:BYTE_BITS]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			a1 <= a_step;
			x1 <= x_step;
			rem_q <= rem10;
			for (int i = 0; i < 5; i++) begin
				half_q[i] <= (m[COUNT_BITS-1:1] == i);
			end
		end
	end

	// second cycle, the even rest as 0, 2, 4, 6 or 8 bytes
	assign half_amt = onehot_index(half_q) * 2 * BYTE_BITS;
	assign rot_amt = onehot_index(rem_q) * 2 * BYTE_BITS;

	assign pair1 = {a1, x1};

	// two copies back to back, so a plain shift gives the rotation
	assign ring = {pair1, pair1};
	assign ring_l = ring << rot_amt;
	assign ring_r = ring >> rot_amt;

	always_comb begin
		outa = a1;
		outx = x1;
		if (sla_q) begin
			outa = (|half_q) ? (a1 << half_amt) : '0;
		end else if (sra_q) begin
			outa = (|half_q) ? (a1 >> half_amt) : '0;
		end else if (slax_q) begin
			{outa, outx} = (|half_q) ? (pair1 << half_amt) : '0;
		end else if (srax_q) begin
			{outa, outx} = (|half_q) ? (pair1 >> half_amt) : '0;
		end else if (slc_q) begin
			{outa, outx} = ring_l[4*WORD_BITS-1:2*WORD_BITS];
		end else if (src_q) begin
			{outa, outx} = ring_r[2*WORD_BITS-1:0];
		end
	end

endmodule

// ==== mix_shift_assertions.sv ====
// protocol checks on the start, done and load pulses of mix_shift_unit, attached by bind
module mix_shift_assertions (
	input logic clk,
	input logic rst,
	input logic start,
	input logic load,
	input logic done
);
	timeunit 1ns;
	timeprecision 100ps;

	// number of protocol violations seen so far
	int violations = 0;

	// every start is answered in the next cycle
	start_gives_done: assert property (@(posedge clk) disable iff (rst) start |=> done)
		else begin
			$error("done did not follow start by one cycle");
			violations++;
		end

	// and no done appears without a start just before it
	done_needs_start: assert property (@(posedge clk) disable iff (rst) done |-> $past(start))
		else begin
			$error("done without a start in the cycle before");
			violations++;
		end

	// stop is a single-cycle pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else begin
			$error("done held high for two cycles");
			violations++;
		end

	// caller rules
	no_start_in_done: assert property (@(posedge clk) disable iff (rst) !(start && done))
		else begin
			$error("start asserted while done is high");
			violations++;
		end

	no_load_clash: assert property (@(posedge clk) disable iff (rst) !(load && (start || done)))
		else begin
			$error("load coincides with start or done");
			violations++;
		end

endmodule

bind mix_shift_unit mix_shift_assertions mix_shift_assertions_i (
	.clk(clk),
	.rst(rst),
	.start(start),
	.load(load),
	.done(done)
);

// ==== mix_shift_unit.sv ====
// top of the MIX shift group, joins register block, shift engine and modulo-10 network
module mix_shift_unit (
	input logic clk,
	input logic rst,
	input logic start,
	input mix_pkg::field_t field,
	input mix_pkg::count_t m,
	input logic load,
	input mix_pkg::mag_t load_a,
	input mix_pkg::mag_t load_x,
	input logic load_sign_a,
	input logic load_sign_x,
	output mix_pkg::mag_t ra,
	output mix_pkg::mag_t rx,
	output logic sign_a,
	output logic sign_x,
	output logic done
);
	import mix_pkg::*;

	// engine results back to the registers
	mag_t shift_a;
	mag_t shift_x;

	rem10_t rem10;

	mix_mod10 mix_mod10_i (
		.m(m),
		.rem10(rem10)
	);

	// register outputs feed the engine directly
	mix_shift mix_shift_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.field(field),
		.m(m),
		.rem10(rem10),
		.ina(ra),
		.inx(rx),
		.outa(shift_a),
		.outx(shift_x),
		.stop(done)
	);

	mix_regs mix_regs_i (
		.clk(clk),
		.rst(rst),
		.load(load),
		.load_a(load_a),
		.load_x(load_x),
		.load_sign_a(load_sign_a),
		.load_sign_x(load_sign_x),
		.outa(shift_a),
		.outx(shift_x),
		.stop(done),
		.ra(ra),
		.rx(rx),
		.sign_a(sign_a),
		.sign_x(sign_x)
	);

endmodule

// ==== project.f ====
mix_pkg.sv
mix_mod10.sv
mix_shift.sv
mix_regs.sv
mix_shift_unit.sv
mix_shift_assertions.sv
tb_mix_shift_unit.sv

// ==== tb_mix_shift_unit.sv ====
// testbench for mix_shift_unit, random loads and shifts checked against a ten-byte model
module tb_mix_shift_unit;
	timeunit 1ns;
	timeprecision 100ps;
	import mix_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 101;
	localparam int DONE_WAIT = 4;

	// expected register state after one shift
	typedef struct packed {
		mag_t a;
		mag_t x;
		logic sa;
		logic sx;
		field_t fld;
		count_t cnt;
	} expect_t;

	logic clk;
	logic rst;
	logic start;
	field_t field;
	count_t m;
	logic load;
	mag_t load_a;
	mag_t load_x;
	logic load_sign_a;
	logic load_sign_x;
	mag_t ra;
	mag_t rx;
	logic sign_a;
	logic sign_x;
	logic done;

	integer seed = 32'hb603_2dbc;

	// model of A, X and the signs
	mag_t model_a;
	mag_t model_x;
	logic model_sa;
	logic model_sx;

	expect_t exp_q[$];
	bit result_due = 1'b0;
	int test_num;
	int pass_count;
	int fail_count;
	int error_count;

	mix_shift_unit mix_shift_unit_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.field(field),
		.m(m),
		.load(load),
		.load_a(load_a),
		.load_x(load_x),
		.load_sign_a(load_sign_a),
		.load_sign_x(load_sign_x),
		.ra(ra),
		.rx(rx),
		.sign_a(sign_a),
		.sign_x(sign_x),
		.done(done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic mag_t rand_mag();
		logic [31:0] v;
		v = $random(seed);
		return v[WORD_BITS-1:0];
	endfunction

	// byte 0 is the leftmost byte of A, byte 9 the rightmost of X
	function automatic logic [2*WORD_BITS-1:0] shift_model(input field_t f, input count_t cnt,
			input mag_t a, input mag_t x);
		logic [BYTE_BITS-1:0] src_b [0:9];
		logic [BYTE_BITS-1:0] dst_b [0:9];
		logic [2*WORD_BITS-1:0] pair;
		int k;
		int j;
		pair = {a, x};
		k = cnt;
		for (int i = 0; i < 10; i++) begin
			src_b[i] = pair[2*WORD_BITS-1-i*BYTE_BITS -: BYTE_BITS];
			dst_b[i] = src_b[i];
		end
		for (int i = 0; i < 10; i++) begin
			case (f)
				FIELD_SLA: begin
					j = i + k;
					if (i < 5) dst_b[i] = (j < 5) ? src_b[j] : '0;
				end
				FIELD_SRA: begin
					j = i - k;
					if (i < 5) dst_b[i] = (j >= 0) ? src_b[j] : '0;
				end
				FIELD_SLAX: begin
					j = i + k;
					dst_b[i] = (j < 10) ? src_b[j] : '0;
				end
				FIELD_SRAX: begin
					j = i - k;
					dst_b[i] = (j >= 0) ? src_b[j] : '0;
				end
				FIELD_SLC: dst_b[i] = src_b[(i + k % 10) % 10];
				FIELD_SRC: dst_b[i] = src_b[(i + 10 - k % 10) % 10];
				default: dst_b[i] = src_b[i];
			endcase
		end
		for (int i = 0; i < 10; i++) begin
			pair[2*WORD_BITS-1-i*BYTE_BITS -: BYTE_BITS] = dst_b[i];
		end
		return pair;
	endfunction

	task automatic compare_regs(input mag_t a, input mag_t x, input logic sa, input logic sx,
			output logic ok);
		ok = 1'b1;
		assert (ra === a) else begin
			$display("Error: ra expected %h, got %h", a, ra);
			ok = 1'b0;
		end
		assert (rx === x) else begin
			$display("Error: rx expected %h, got %h", x, rx);
			ok = 1'b0;
		end
		assert (sign_a === sa) else begin
			$display("Error: sign_a expected %h, got %h", sa, sign_a);
			ok = 1'b0;
		end
		assert (sign_x === sx) else begin
			$display("Error: sign_x expected %h, got %h", sx, sign_x);
			ok = 1'b0;
		end
	endtask

	task automatic load_regs(input mag_t a, input mag_t x, input logic sa, input logic sx);
		@(posedge clk);
		load <= 1'b1;
		load_a <= a;
		load_x <= x;
		load_sign_a <= sa;
		load_sign_x <= sx;
		@(posedge clk);
		load <= 1'b0;
		model_a = a;
		model_x = x;
		model_sa = sa;
		model_sx = sx;
	endtask

	// returns in the done cycle, so the next command can start one cycle later
	task automatic issue_shift(input field_t f, input count_t cnt);
		logic [2*WORD_BITS-1:0] res;
		expect_t e;
		int waited;
		res = shift_model(f, cnt, model_a, model_x);
		model_a = res[2*WORD_BITS-1:WORD_BITS];
		model_x = res[WORD_BITS-1:0];
		e.a = model_a;
		e.x = model_x;
		e.sa = model_sa;
		e.sx = model_sx;
		e.fld = f;
		e.cnt = cnt;
		exp_q.push_back(e);
		@(posedge clk);
		start <= 1'b1;
		field <= f;
		m <= cnt;
		@(posedge clk);
		start <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (done !== 1'b1 && waited < DONE_WAIT) begin
			waited++;
			@(negedge clk);
		end
		assert (done === 1'b1) else begin
			$display("no done pulse for shift field %0d m %0d", f, cnt);
			error_count++;
		end
	endtask

	// result is in the registers one cycle after done
	always @(negedge clk) begin
		expect_t e;
		logic ok;
		if (result_due) begin
			if (exp_q.size() == 0) begin
				$display("done pulse without a pending shift");
				error_count++;
			end else begin
				e = exp_q.pop_front();
				compare_regs(e.a, e.x, e.sa, e.sx, ok);
				test_num++;
				if (ok) begin
					pass_count++;
					$display("test %0d: field %0d m %0d ok", test_num, e.fld, e.cnt);
				end else begin
					fail_count++;
					$display("test %0d: field %0d m %0d FAILED", test_num, e.fld, e.cnt);
				end
			end
		end
		result_due = (done === 1'b1);
	end

	initial begin
		#((NUM_TESTS * 10 + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the run did not finish in the expected time");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic ok;
		logic ok_load;
		int violations;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		field = '0;
		m = '0;
		load = 1'b0;
		load_a = '0;
		load_x = '0;
		load_sign_a = 1'b0;
		load_sign_x = 1'b0;
		test_num = 0;
		pass_count = 0;
		fail_count = 0;
		error_count = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		// reset state, then a load seen one cycle later
		@(negedge clk);
		compare_regs('0, '0, 1'b0, 1'b0, ok);
		assert (done === 1'b0) else begin
			$display("Error: done expected %h, got %h", 1'b0, done);
			ok = 1'b0;
		end
		load_regs(rand_mag(), rand_mag(), 1'b1, 1'b0);
		@(negedge clk);
		compare_regs(model_a, model_x, model_sa, model_sx, ok_load);
		test_num++;
		if (ok && ok_load) begin
			pass_count++;
			$display("test %0d: reset and load ok", test_num);
		end else begin
			fail_count++;
			$display("test %0d: reset and load FAILED", test_num);
		end

		// single-register shifts
		for (int i = 0; i < 20; i++) begin
			load_regs(rand_mag(), rand_mag(), rand_below(2), rand_below(2));
			issue_shift((i % 2) ? FIELD_SRA : FIELD_SLA, rand_below(13));
		end

		// A:X shifts
		for (int i = 0; i < 20; i++) begin
			load_regs(rand_mag(), rand_mag(), rand_below(2), rand_below(2));
			issue_shift((i % 2) ? FIELD_SRAX : FIELD_SLAX, rand_below(16));
		end

		// rotations over the full count range
		for (int i = 0; i < 24; i++) begin
			load_regs(rand_mag(), rand_mag(), rand_below(2), rand_below(2));
			issue_shift((i % 2) ? FIELD_SRC : FIELD_SLC, rand_below(4096));
		end

		// fields with no shift
		for (int i = 0; i < 12; i++) begin
			load_regs(rand_mag(), rand_mag(), rand_below(2), rand_below(2));
			issue_shift(6 + rand_below(58), rand_below(4096));
		end

		// chained commands, each on the previous result
		load_regs(rand_mag(), rand_mag(), rand_below(2), rand_below(2));
		for (int i = 0; i < 24; i++) begin
			if (rand_below(4) == 0) begin
				load_regs(rand_mag(), rand_mag(), rand_below(2), rand_below(2));
			end
			issue_shift(rand_below(6), rand_below(16));
		end

		repeat (3) @(negedge clk);
		assert (exp_q.size() == 0) else begin
			$display("%0d shift results were never written back", exp_q.size());
			error_count++;
		end
		violations = mix_shift_unit_i.mix_shift_assertions_i.violations;
		$display("tests %0d, passed %0d, failed %0d, other errors %0d, violations %0d",
			test_num, pass_count, fail_count, error_count, violations);
		if (fail_count == 0 && error_count == 0 && violations == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
